//--- dsp_router.f
verilog/dsp_route_pkg.sv
verilog/dsp_bus_pkg.sv
verilog/dsp_config_regs.sv
verilog/dsp_signal_matrix.sv
verilog/dsp_output_summer.sv
verilog/dsp_router.sv
verification/dsp_router_assertions.sv
verification/dsp_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dsp_router testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module dsp_router_tb -f dsp_router.f -o dsp_router_sim

./obj_dir/dsp_router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q "sim passed" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi

//--- verification/dsp_router_tb.sv
////////////////////
// directed tests, stops at the first mismatch
// inputs change 10 units after the rising edge
////////////////////
`default_nettype none

module dsp_router_tb
   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;
();

   logic clk_i = 1'b0;
   logic rstn_i = 1'b0;
   sample_t adc_a_i, adc_b_i, asg1_i, asg2_i;
   sample_t [NUM_PROC-1:0] proc_i, proc_o;
   sample_t scope1_o, scope2_o, pwm0_o, pwm1_o, dac_a_o, dac_b_o;
   bus_req_t bus_req_i;
   bus_rsp_t bus_rsp_o;
   logic [31:0] lfsr_q = 32'h85b3;              // sample generator state

   dsp_router dsp_router_inst (.*);

   always #50 clk_i = ~clk_i;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_sample(output sample_t v);
      int i;
      for (i = 0; i < SAMPLE_W; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v[i]   = lfsr_q[0];                    // one step per bit
      end
   endtask

   task automatic report_failure();
      $display("sim failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_eq(input string test, input int exp, input int got);
      assert (got == exp) else begin
         $display("error: %s expected %0d got %0d", test, exp, got);
         report_failure();
      end
   endtask

   ////////////////////
   // bus access
   ////////////////////

   // called and returns 10 units after a rising edge
   task automatic bus_access(input logic wr, input int slot, input int off,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int n;
      n = 0;
      bus_req_i = '{addr: {slot[15:0], off[15:0]}, wdata: wdata, wen: wr, ren: !wr};
      @(posedge clk_i);
      #10;
      bus_req_i.wen = 1'b0;
      bus_req_i.ren = 1'b0;
      while (!bus_rsp_o.ack && n < 20) begin
         @(posedge clk_i);
         #10;
         n++;
      end
      if (!bus_rsp_o.ack) begin
         $display("bus ack did not arrive within 20 cycles");
         report_failure();
      end
      rdata = bus_rsp_o.rdata;
      err   = bus_rsp_o.err;
   endtask

   task automatic write_reg(input string test, input int slot, input int off, input int data);
      logic [31:0] rd;
      logic        err;
      bus_access(1'b1, slot, off, data, rd, err);
      check_eq({test, " write err"}, 0, err);
   endtask

   task automatic read_reg(input string test, input int slot, input int off, input int exp);
      logic [31:0] rd;
      logic        err;
      bus_access(1'b0, slot, off, '0, rd, err);
      check_eq({test, " read err"}, 0, err);
      check_eq(test, exp, rd);
   endtask

   ////////////////////
   // directed tests
   ////////////////////

   task automatic reset_defaults();
      int p;
      check_eq("reset_defaults scope1", adc_a_i, scope1_o);
      check_eq("reset_defaults scope2", adc_b_i, scope2_o);
      for (p = 0; p < NUM_PROC; p++) check_eq("reset_defaults proc", adc_a_i, proc_o[p]);
      check_eq("reset_defaults pwm0", 0, pwm0_o);
      check_eq("reset_defaults pwm1", 0, pwm1_o);
      check_eq("reset_defaults dac_a", 0, dac_a_o);
      check_eq("reset_defaults dac_b", 0, dac_b_o);
   endtask

   task automatic input_routing();
      next_sample(asg2_i);
      next_sample(proc_i[1]);
      write_reg("input_routing", SINK_SCOPE1, REG_IN_SEL, ASG2);
      write_reg("input_routing", SINK_PWM0, REG_IN_SEL, PROC1);
      read_reg("input_routing scope1 sel", SINK_SCOPE1, REG_IN_SEL, 5);
      read_reg("input_routing pwm0 sel", SINK_PWM0, REG_IN_SEL, 1);
      check_eq("input_routing scope1", asg2_i, scope1_o);
      check_eq("input_routing pwm0", proc_i[1], pwm0_o);
   endtask

   task automatic summing();
      next_sample(proc_i[0]);
      next_sample(asg1_i);
      proc_i[0] = proc_i[0] >>> 1;              // halve so the sum stays in range
      asg1_i    = asg1_i >>> 1;
      write_reg("summing", 0, REG_OUT_SEL, OUT_A);   // proc0 -> a
      write_reg("summing", 4, REG_OUT_SEL, BOTH);    // asg1 -> a and b
      repeat (5) @(posedge clk_i);              // tree latency is 4
      #10;
      check_eq("summing dac_a", proc_i[0] + asg1_i, dac_a_o);
      check_eq("summing dac_b", asg1_i, dac_b_o);
      write_reg("summing", SINK_PWM1, REG_IN_SEL, DAC1);
      check_eq("summing pwm1", proc_i[0] + asg1_i, pwm1_o);
   endtask

   task automatic saturation();
      int s;
      for (s = 0; s < 3; s++) proc_i[s] = 14'sd8000;
      proc_i[3] = -14'sd8000;
      asg1_i    = -14'sd8000;
      asg2_i    = -14'sd7990;
      for (s = 0; s < NUM_DIRECT; s++) write_reg("saturation", s, REG_OUT_SEL, s < 3 ? 1 : 2);
      repeat (5) @(posedge clk_i);
      #10;
      check_eq("saturation dac_a", 8191, dac_a_o);
      check_eq("saturation dac_b", -8192, dac_b_o);
      read_reg("saturation flags", 0, REG_SAT, 3);
   endtask

   task automatic readback_errors();
      logic [31:0] rd;
      logic        err;
      int          s;
      read_reg("readback adc2", ADC2, REG_SRC_RD, {18'd0, adc_b_i});
      bus_access(1'b0, 0, 16'h0020, '0, rd, err);
      check_eq("readback unmapped err", 1, err);
      bus_access(1'b1, 7, REG_OUT_SEL, 32'h3, rd, err);    // no out select at slot 7
      check_eq("readback slot7 err", 1, err);
      for (s = 0; s < NUM_DIRECT; s++) read_reg("readback out_sel", s, REG_OUT_SEL, s < 3 ? 1 : 2);
      read_reg("readback pwm1 sel", SINK_PWM1, REG_IN_SEL, 8);
      read_reg("readback proc0 sel", 0, REG_IN_SEL, 6);
   endtask

   initial begin
      adc_a_i   = 14'sd1234;                    // distinct so the scopes differ
      adc_b_i   = -14'sd2345;
      asg1_i    = 14'sd111;
      asg2_i    = 14'sd222;
      proc_i    = '{14'sd44, 14'sd33, 14'sd22, 14'sd11};
      bus_req_i = '0;
      repeat (8) @(posedge clk_i);
      #10;
      bus_req_i.ren = 1'b1;                     // strobe inside reset, must not ack
      @(posedge clk_i);
      #10;
      bus_req_i.ren = 1'b0;
      repeat (7) @(posedge clk_i);
      #10;
      rstn_i = 1'b1;
      reset_defaults();
      input_routing();
      summing();
      saturation();
      readback_errors();
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/dsp_router_assertions.sv
////////////////////
// bound into dsp_config_regs, watches the register bus handshake
////////////////////
`default_nettype none

module dsp_router_assertions
   import dsp_bus_pkg::*;
(
   input logic     clk_i,
   input logic     rstn_i,
   input bus_req_t bus_req_i,
   input bus_rsp_t bus_rsp_i
);

   logic en;
   assign en = bus_req_i.wen | bus_req_i.ren;   // either strobe starts a transfer

   // one ack per enable, the cycle after it
   ack_follows_en: assert property (@(posedge clk_i)
      $past(rstn_i) |-> (bus_rsp_i.ack == $past(en)))
      else $error("ack is not a single cycle after the bus enable");

   err_needs_ack: assert property (@(posedge clk_i) bus_rsp_i.err |-> bus_rsp_i.ack)
      else $error("err raised without ack");

   // registered ack, so checked one edge into reset
   no_ack_in_reset: assert property (@(posedge clk_i) !$past(rstn_i) |-> !bus_rsp_i.ack)
      else $error("ack high while in reset");

endmodule

bind dsp_config_regs dsp_router_assertions dsp_router_assertions_inst (
   .clk_i     (clk_i),
   .rstn_i    (rstn_i),
   .bus_req_i (bus_req_i),
   .bus_rsp_i (bus_rsp_o)
);

`default_nettype wire

//--- verilog/dsp_router.sv
////////////////////
// routing matrix top, config regs + matrix + dac summer
// processing slots are external ports, nothing is forwarded on the bus
////////////////////
`default_nettype none

module dsp_router
   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    rstn_i,
   input  sample_t                 adc_a_i,
   input  sample_t                 adc_b_i,
   input  sample_t                 asg1_i,
   input  sample_t                 asg2_i,
   input  sample_t [NUM_PROC-1:0]  proc_i,     // from external slots
   output sample_t [NUM_PROC-1:0]  proc_o,     // to external slots
   output sample_t                 scope1_o,
   output sample_t                 scope2_o,
   output sample_t                 pwm0_o,
   output sample_t                 pwm1_o,
   output sample_t                 dac_a_o,
   output sample_t                 dac_b_o,
   input  bus_req_t                bus_req_i,
   output bus_rsp_t                bus_rsp_o
);

   route_cfg_t         cfg;                    // selects, to matrix and summer
   src_vec_t           src_vec;                // all sources, code order
   logic [NUM_DAC-1:0] sat;

   dsp_config_regs dsp_config_regs_inst (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .bus_req_i (bus_req_i),
      .src_vec_i (src_vec),
      .sat_i     (sat),
      .bus_rsp_o (bus_rsp_o),
      .cfg_o     (cfg)
   );

   dsp_signal_matrix dsp_signal_matrix_inst (
      .adc_a_i   (adc_a_i),
      .adc_b_i   (adc_b_i),
      .asg1_i    (asg1_i),
      .asg2_i    (asg2_i),
      .proc_i    (proc_i),
      .dac_a_i   (dac_a_o),                    // dac feedback
      .dac_b_i   (dac_b_o),
      .cfg_i     (cfg),
      .src_vec_o (src_vec),
      .proc_o    (proc_o),
      .scope1_o  (scope1_o),
      .scope2_o  (scope2_o),
      .pwm0_o    (pwm0_o),
      .pwm1_o    (pwm1_o)
   );

   dsp_output_summer dsp_output_summer_inst (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .direct_i  (src_vec[NUM_DIRECT-1:0]),    // procs + asgs only
      .cfg_i     (cfg),
      .dac_a_o   (dac_a_o),
      .dac_b_o   (dac_b_o),
      .sat_o     (sat)
   );

endmodule

`default_nettype wire

//--- verilog/dsp_output_summer.sv
////////////////////
// 4 cycles from direct source or out_sel change to dac output
// flags are per cycle, not sticky
////////////////////
`default_nettype none

module dsp_output_summer
   import dsp_route_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  sample_t [NUM_DIRECT-1:0]  direct_i,   // source codes 0..5
   input  route_cfg_t                cfg_i,
   output sample_t                   dac_a_o,
   output sample_t                   dac_b_o,
   output logic [NUM_DAC-1:0]        sat_o       // bit0 = a, bit1 = b
);

   typedef logic signed [SUM_W-1:0] acc_t;

   acc_t    [NUM_DAC-1:0][TREE_LEAVES-1:0]   leaf;    // gated, sign extended
   acc_t    [NUM_DAC-1:0][TREE_LEAVES/2-1:0] pair_q;  // stage 1
   acc_t    [NUM_DAC-1:0][TREE_LEAVES/4-1:0] lvl1_q;  // stage 2
   acc_t    [NUM_DAC-1:0]                    lvl2_q;  // stage 3
   acc_t    [NUM_DAC-1:0]                    sum_q;   // stage 4, output reg
   sample_t [NUM_DAC-1:0]                    dac;

   ////////////////////
   // gating per channel
   ////////////////////

   always_comb begin
      leaf = '0;                               // padded leaves stay zero
      for (int ch = 0; ch < NUM_DAC; ch++) begin
         for (int l = 0; l < NUM_DIRECT; l++) begin
            if (cfg_i.out_sel[l][ch]) begin    // out_sel bit = channel enable
               leaf[ch][l] = {{(SUM_W-SAMPLE_W){direct_i[l][SAMPLE_W-1]}}, direct_i[l]};
            end
         end
      end
   end

   ////////////////////
   // adder tree
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         pair_q <= '0;
         lvl1_q <= '0;
         lvl2_q <= '0;
         sum_q  <= '0;                         // dacs come out of reset at 0
      end else begin
         for (int ch = 0; ch < NUM_DAC; ch++) begin
            for (int p = 0; p < TREE_LEAVES/2; p++) begin
               pair_q[ch][p] <= leaf[ch][2*p] + leaf[ch][2*p+1];
            end
            for (int q = 0; q < TREE_LEAVES/4; q++) begin
               lvl1_q[ch][q] <= pair_q[ch][2*q] + pair_q[ch][2*q+1];
            end
            lvl2_q[ch] <= lvl1_q[ch][0] + lvl1_q[ch][1];
            sum_q[ch]  <= lvl2_q[ch];          // extra reg for timing slack
         end
      end
   end

   // clamp to 14 bits straight off the output register
   always_comb begin
      for (int ch = 0; ch < NUM_DAC; ch++) begin
         if (sum_q[ch] > SAMPLE_MAX) begin
            dac[ch]   = sample_t'(SAMPLE_MAX);
            sat_o[ch] = 1'b1;
         end else if (sum_q[ch] < SAMPLE_MIN) begin
            dac[ch]   = sample_t'(SAMPLE_MIN);
            sat_o[ch] = 1'b1;
         end else begin
            dac[ch]   = sum_q[ch][SAMPLE_W-1:0];
            sat_o[ch] = 1'b0;
         end
      end
   end

   assign dac_a_o = dac[0];
   assign dac_b_o = dac[1];

endmodule

`default_nettype wire

//--- verilog/dsp_signal_matrix.sv
////////////////////
// purely combinational, sinks follow their source in the same cycle
////////////////////
`default_nettype none

module dsp_signal_matrix
   import dsp_route_pkg::*;
(
   input  sample_t                 adc_a_i,
   input  sample_t                 adc_b_i,
   input  sample_t                 asg1_i,
   input  sample_t                 asg2_i,
   input  sample_t [NUM_PROC-1:0]  proc_i,    // slot outputs
   input  sample_t                 dac_a_i,   // fed back from summer
   input  sample_t                 dac_b_i,
   input  route_cfg_t              cfg_i,
   output src_vec_t                src_vec_o,
   output sample_t [NUM_PROC-1:0]  proc_o,    // slot inputs
   output sample_t                 scope1_o,
   output sample_t                 scope2_o,
   output sample_t                 pwm0_o,
   output sample_t                 pwm1_o
);

   sample_t [NUM_SINK-1:0] sink;

   // source vector, index is the select code
   always_comb begin
      for (int p = 0; p < NUM_PROC; p++) begin
         src_vec_o[PROC0 + p] = proc_i[p];
      end
      src_vec_o[ASG1] = asg1_i;
      src_vec_o[ASG2] = asg2_i;
      src_vec_o[ADC1] = adc_a_i;
      src_vec_o[ADC2] = adc_b_i;
      src_vec_o[DAC1] = dac_a_i;
      src_vec_o[DAC2] = dac_b_i;
   end

   // one mux per sink, none and unused codes give zero
   always_comb begin
      for (int k = 0; k < NUM_SINK; k++) begin
         if (cfg_i.in_sel[k] < NUM_SRC) sink[k] = src_vec_o[cfg_i.in_sel[k]];
         else                           sink[k] = '0;
      end
   end

   always_comb begin
      for (int p = 0; p < NUM_PROC; p++) proc_o[p] = sink[p];
   end

   assign scope1_o = sink[SINK_SCOPE1];
   assign scope2_o = sink[SINK_SCOPE2];
   assign pwm0_o   = sink[SINK_PWM0];
   assign pwm1_o   = sink[SINK_PWM1];

endmodule

`default_nettype wire

//--- verilog/dsp_config_regs.sv
////////////////////
// ack one cycle after wen/ren, no back-pressure, one request per cycle max
// writes to read-only offsets are acked and dropped
////////////////////
`default_nettype none

module dsp_config_regs
   import dsp_route_pkg::*;
   import dsp_bus_pkg::*;
(
   input  logic               clk_i,
   input  logic               rstn_i,
   input  bus_req_t           bus_req_i,
   input  src_vec_t           src_vec_i,   // raw sources for readback
   input  logic [NUM_DAC-1:0] sat_i,       // per-cycle clamp flags
   output bus_rsp_t           bus_rsp_o,
   output route_cfg_t         cfg_o
);

   ////////////////////
   // address decode
   ////////////////////

   logic [OFF_W-1:0]            off;
   logic [ADDR_W-OFF_W-1:0]     slot;
   logic [$clog2(NUM_SINK)-1:0] sink_idx;  // in/out select index
   logic [SRC_W-1:0]            src_idx;   // readback index
   logic                        en;
   logic                        hit;       // offset mapped and slot exists
   logic [DATA_W-1:0]           rdata_d;

   route_cfg_t                  cfg_q;
   logic                        ack_q;
   logic                        err_q;
   logic [DATA_W-1:0]           rdata_q;

   assign off      = bus_req_i.addr[OFF_W-1:0];
   assign slot     = bus_req_i.addr[ADDR_W-1:OFF_W];
   assign sink_idx = slot[$clog2(NUM_SINK)-1:0];
   assign src_idx  = slot[SRC_W-1:0];
   assign en       = bus_req_i.wen | bus_req_i.ren;

   always_comb begin
      hit     = 1'b0;
      rdata_d = '0;
      case (reg_off_e'(off))
         REG_IN_SEL: begin
            hit = (slot < NUM_SINK);
            if (hit) rdata_d[SRC_W-1:0] = cfg_q.in_sel[sink_idx];
         end
         REG_OUT_SEL: begin
            hit = (slot < NUM_DIRECT);         // only direct sources have one
            if (hit) rdata_d[1:0] = cfg_q.out_sel[sink_idx];
         end
         REG_SAT: begin
            hit                   = 1'b1;      // global, slot ignored
            rdata_d[NUM_DAC-1:0] = sat_i;
         end
         REG_SRC_RD: begin
            hit = (slot < NUM_SRC);
            if (hit) rdata_d[SAMPLE_W-1:0] = src_vec_i[src_idx]; // zero extended
         end
         default: hit = 1'b0;                  // unmapped -> err
      endcase
   end

   ////////////////////
   // select registers
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         cfg_q <= ROUTE_CFG_RST;
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= en;
         err_q <= en & ~hit;
         // write lands on the same edge that raises ack
         if (bus_req_i.wen && hit) begin
            case (reg_off_e'(off))
               REG_IN_SEL:
                  cfg_q.in_sel[sink_idx] <= src_id_e'(bus_req_i.wdata[SRC_W-1:0]);
               REG_OUT_SEL:
                  cfg_q.out_sel[sink_idx] <= out_sel_e'(bus_req_i.wdata[1:0]);
               default: ;                      // read-only, nothing to store
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (en) rdata_q <= rdata_d;              // hold last read data otherwise
   end

   assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};
   assign cfg_o     = cfg_q;

endmodule

`default_nettype wire

//--- verilog/dsp_bus_pkg.sv
////////////////////
// register bus, slot number in addr[31:16], offset in addr[15:0]
// no byte select, whole 32-bit words only
////////////////////
`default_nettype none

package dsp_bus_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int OFF_W  = 16;                           // low address bits = register offset

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              wen;                            // one-cycle strobe
      logic              ren;                            // one-cycle strobe
   } bus_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;                          // valid with ack
      logic              ack;
      logic              err;                            // only together with ack
   } bus_rsp_t;

   typedef enum logic [OFF_W-1:0] {
      REG_IN_SEL  = 16'h0000,
      REG_OUT_SEL = 16'h0004,
      REG_SAT     = 16'h0008,                            // read only
      REG_SRC_RD  = 16'h0010                             // read only
   } reg_off_e;

endpackage

`default_nettype wire

//--- verilog/dsp_route_pkg.sv
////////////////////
// sample, source and sink numbering shared by the whole routing matrix
// select codes 10..14 are legal to write but route as zero
////////////////////
`default_nettype none

package dsp_route_pkg;

   localparam int SAMPLE_W   = 14;                       // adc/dac width
   localparam int SAMPLE_MAX = 2**(SAMPLE_W-1) - 1;      // 8191
   localparam int SAMPLE_MIN = -(2**(SAMPLE_W-1));       // -8192

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // source codes as written into the input select register
   localparam int SRC_W = 4;
   typedef enum logic [SRC_W-1:0] {
      PROC0 = 4'd0, PROC1 = 4'd1, PROC2 = 4'd2, PROC3 = 4'd3,
      ASG1  = 4'd4, ASG2  = 4'd5,
      ADC1  = 4'd6, ADC2  = 4'd7,
      DAC1  = 4'd8, DAC2  = 4'd9,
      SRC_NONE = 4'd15                                   // routes zero
   } src_id_e;

   localparam int NUM_SRC    = 10;                       // real sources
   localparam int NUM_DIRECT = 6;                        // codes 0..5 can feed the dacs
   localparam int NUM_PROC   = 4;                        // external processing slots

   // sink numbering, processing inputs sit at 0..3
   localparam int SINK_SCOPE1 = 4;
   localparam int SINK_SCOPE2 = 5;
   localparam int SINK_PWM0   = 6;
   localparam int SINK_PWM1   = 7;
   localparam int NUM_SINK    = 8;

   // bit0 = dac a, bit1 = dac b
   typedef enum logic [1:0] {OFF = 2'b00, OUT_A = 2'b01, OUT_B = 2'b10, BOTH = 2'b11} out_sel_e;

   localparam int NUM_DAC     = 2;
   localparam int TREE_LEAVES = 8;                       // direct sources padded to 2**n
   localparam int SUM_W       = 18;                      // headroom for 8 full-scale adds

   typedef sample_t [NUM_SRC-1:0] src_vec_t;             // index = source code

   typedef struct packed {
      src_id_e  [NUM_SINK-1:0]   in_sel;                 // one per sink
      out_sel_e [NUM_DIRECT-1:0] out_sel;                // one per direct source
   } route_cfg_t;

   localparam route_cfg_t ROUTE_CFG_RST = '{
      in_sel:  '{SINK_PWM1: SRC_NONE, SINK_PWM0: SRC_NONE, SINK_SCOPE2: ADC2, default: ADC1},
      out_sel: '{default: OFF}
   };

endpackage

`default_nettype wire
